// ==== Makefile ====
# Verilator build for the RV32IM core and its testbench

VERILATOR  ?= verilator
FILELIST   ?= verilog.f
TB_TOP     ?= tb_rv_core
RTL_TOP    ?= rv_core
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) hw/*.sv tests/*.sv tests/*.svh
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG) || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/rv_alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU
// arithmetic, logic, shifts, LUI and the
// six branch compares
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module rv_alu import rv_pkg::*; (
  input  alu_op_e         alu_op,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  logic [XLEN-1:0] pc,
  output logic [XLEN-1:0] alu_result,
  output logic            branch_taken
);

  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic [4:0]      shamt;
  logic [XLEN-1:0] fall_through;

  // compares are shared by SLT/SLTU and the branches
  assign eq    = (a == b);
  assign lt_s  = ($signed(a) < $signed(b));
  assign lt_u  = (a < b);
  assign shamt = b[4:0];

  // sequential successor, shown on the result bus for branch ops
  assign fall_through = pc + XLEN'(4);

  always_comb begin
    alu_result   = fall_through;
    branch_taken = 1'b0;
    case (alu_op)
      ALU_ADD:  alu_result = a + b;
      ALU_SUB:  alu_result = a - b;
      ALU_SLL:  alu_result = a << shamt;
      ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  alu_result = a ^ b;
      ALU_SRL:  alu_result = a >> shamt;
      ALU_SRA:  alu_result = $unsigned($signed(a) >>> shamt);
      ALU_OR:   alu_result = a | b;
      ALU_AND:  alu_result = a & b;
      ALU_LUI:  alu_result = b;
      ALU_BEQ:  branch_taken = eq;
      ALU_BNE:  branch_taken = !eq;
      ALU_BLT:  branch_taken = lt_s;
      ALU_BGE:  branch_taken = !lt_s;
      ALU_BLTU: branch_taken = lt_u;
      ALU_BGEU: branch_taken = !lt_u;
      default:  alu_result = '0;
    endcase
  end

endmodule

// ==== hw/rv_commit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Commit unit
// owns pc and halt, picks the write-back
// value and drives the retire port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module rv_commit import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  wb_sel_e               wb_sel,
  input  pc_sel_e               pc_sel,
  input  logic                  is_ecall,
  input  logic [REG_ADDR_W-1:0] rd,
  input  logic [XLEN-1:0]       alu_result,
  input  logic                  branch_taken,
  input  logic [XLEN-1:0]       md_result,
  input  logic                  md_stall,
  input  logic [XLEN-1:0]       imm,
  output logic [XLEN-1:0]       pc,
  output logic                  halt,
  output logic                  rf_we,
  output logic [REG_ADDR_W-1:0] rf_rd,
  output logic [XLEN-1:0]       rf_wdata,
  output logic                  retire_valid,
  output logic [XLEN-1:0]       retire_pc,
  output logic                  retire_we,
  output logic [REG_ADDR_W-1:0] retire_rd,
  output logic [XLEN-1:0]       retire_data
);

  logic [XLEN-1:0] link;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] next_pc;
  logic            advance;

  assign link    = pc + XLEN'(4);
  assign target  = pc + imm;
  // the divider stall and halt are the only things that hold pc
  assign advance = !md_stall && !halt;

  always_comb begin
    case (wb_sel)
      WB_ALU:    rf_wdata = alu_result;
      WB_MULDIV: rf_wdata = md_result;
      WB_LINK:   rf_wdata = link;
      default:   rf_wdata = '0;
    endcase
  end

  assign rf_rd = rd;
  assign rf_we = advance && (wb_sel != WB_NONE) && (rd != '0);

  always_comb begin
    case (pc_sel)
      PC_BRANCH: next_pc = branch_taken ? target : link;
      PC_JAL:    next_pc = target;
      PC_JALR:   next_pc = {alu_result[XLEN-1:1], 1'b0};
      default:   next_pc = link;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= '0;
      halt         <= 1'b0;
      retire_valid <= 1'b0;
      retire_we    <= 1'b0;
    end else begin
      retire_valid <= advance;
      retire_we    <= rf_we;
      // ecall leaves pc on itself
      if (advance && is_ecall) begin
        halt <= 1'b1;
      end else if (advance) begin
        pc <= next_pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      retire_pc   <= pc;
      retire_rd   <= rd;
      retire_data <= rf_wdata;
    end
  end

endmodule

// ==== hw/rv_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32IM multi-cycle core top level
// decoder, registers, ALU, muldiv, commit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module rv_core import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [XLEN-1:0]       insn,
  output logic [XLEN-1:0]       pc,
  output logic                  halt,
  output logic                  retire_valid,
  output logic [XLEN-1:0]       retire_pc,
  output logic                  retire_we,
  output logic [REG_ADDR_W-1:0] retire_rd,
  output logic [XLEN-1:0]       retire_data
);

  logic [REG_ADDR_W-1:0] rs1, rs2, rd, rf_rd;
  logic [XLEN-1:0]       imm, rs1_data, rs2_data, op_a, op_b;
  logic [XLEN-1:0]       alu_result, md_result, rf_wdata;
  alu_op_e               alu_op;
  md_op_e                md_op;
  wb_sel_e               wb_sel;
  pc_sel_e               pc_sel;
  logic                  use_imm, is_ecall, branch_taken, md_stall, rf_we;

  rv_decoder u_decoder (
    .insn, .rs1, .rs2, .rd, .imm, .alu_op, .use_imm, .md_op, .wb_sel, .pc_sel, .is_ecall
  );

  rv_regfile u_regfile (
    .clk, .rst, .we(rf_we), .rd(rf_rd), .rd_data(rf_wdata), .rs1, .rs2, .rs1_data, .rs2_data
  );

  // AUIPC adds to pc, everything else reads rs1
  assign op_a = (insn[6:0] == OP_AUIPC) ? pc : rs1_data;
  assign op_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (.alu_op, .a(op_a), .b(op_b), .pc, .alu_result, .branch_taken);

  rv_muldiv u_muldiv (
    .clk, .rst, .md_op, .a(rs1_data), .b(rs2_data), .md_result, .md_stall
  );

  rv_commit u_commit (
    .clk, .rst, .wb_sel, .pc_sel, .is_ecall, .rd, .alu_result, .branch_taken, .md_result,
    .md_stall, .imm, .pc, .halt, .rf_we, .rf_rd, .rf_wdata, .retire_valid, .retire_pc,
    .retire_we, .retire_rd, .retire_data
  );

endmodule

// ==== hw/rv_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder
// splits fields, builds the immediates and
// picks the ALU, muldiv and commit controls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module rv_decoder import rv_pkg::*; (
  input  logic [XLEN-1:0]       insn,
  output logic [REG_ADDR_W-1:0] rs1,
  output logic [REG_ADDR_W-1:0] rs2,
  output logic [REG_ADDR_W-1:0] rd,
  output logic [XLEN-1:0]       imm,
  output alu_op_e               alu_op,
  output logic                  use_imm,
  output md_op_e                md_op,
  output wb_sel_e               wb_sel,
  output pc_sel_e               pc_sel,
  output logic                  is_ecall
);

  logic [6:0]      funct7;
  logic [2:0]      funct3;
  opcode_e         opcode;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  assign opcode = opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // sign-extended immediates, B and J carry an implied zero lsb
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    imm      = '0;
    alu_op   = ALU_ADD;
    use_imm  = 1'b0;
    md_op    = MD_NONE;
    wb_sel   = WB_NONE;
    pc_sel   = PC_SEQ;
    is_ecall = 1'b0;
    case (opcode)
      OP_LUI, OP_AUIPC: begin
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = (opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
        wb_sel  = WB_ALU;
      end
      OP_JAL: begin
        imm    = imm_j;
        wb_sel = WB_LINK;
        pc_sel = PC_JAL;
      end
      OP_JALR: begin
        imm     = imm_i;
        use_imm = 1'b1;
        if (funct3 == 3'b000) begin
          wb_sel = WB_LINK;
          pc_sel = PC_JALR;
        end
      end
      OP_BRANCH: begin
        imm    = imm_b;
        pc_sel = PC_BRANCH;
        case (funct3)
          3'b000:  alu_op = ALU_BEQ;
          3'b001:  alu_op = ALU_BNE;
          3'b100:  alu_op = ALU_BLT;
          3'b101:  alu_op = ALU_BGE;
          3'b110:  alu_op = ALU_BLTU;
          3'b111:  alu_op = ALU_BGEU;
          default: pc_sel = PC_SEQ;
        endcase
      end
      OP_REG_IMM, OP_REG_REG: begin
        imm     = imm_i;
        use_imm = (opcode == OP_REG_IMM);
        wb_sel  = WB_ALU;
        if (opcode == OP_REG_REG && funct7 == 7'b0000001) begin
          wb_sel = WB_MULDIV;
          md_op  = md_op_e'(funct3 + 4'd1);
        end else begin
          case (funct3)
            3'b000: alu_op = (use_imm || funct7 == 7'b0) ? ALU_ADD : ALU_SUB;
            3'b001: alu_op = ALU_SLL;
            3'b010: alu_op = ALU_SLT;
            3'b011: alu_op = ALU_SLTU;
            3'b100: alu_op = ALU_XOR;
            3'b101: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110: alu_op = ALU_OR;
            default: alu_op = ALU_AND;
          endcase
          // only shifts and reg-reg ops constrain funct7
          if ((!use_imm || funct3 == 3'b001 || funct3 == 3'b101) &&
              !(funct7 == 7'b0 || (funct7 == 7'b0100000 &&
                (funct3 == 3'b101 || (!use_imm && funct3 == 3'b000))))) begin
            wb_sel = WB_NONE;
          end
        end
      end
      OP_ENVIRON: is_ecall = (insn[31:7] == '0);
      // FENCE and unknown encodings fall through as no-ops
      default: ;
    endcase
  end

endmodule

// ==== hw/rv_muldiv.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply / divide unit
// single-cycle multiply, iterative restoring
// divide that stalls the core until done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module rv_muldiv import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  md_op_e          md_op,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  output logic [XLEN-1:0] md_result,
  output logic            md_stall
);

  typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_e;

  div_state_e                    state;
  logic [$clog2(DIV_STEPS)-1:0] step;
  logic [XLEN-1:0]               quo;
  logic [XLEN-1:0]               rem;
  logic [XLEN-1:0]               dvsr;
  logic [XLEN-1:0]               dvnd_raw;
  logic                          neg_quo;
  logic                          neg_rem;
  logic                          div_zero;
  logic                          is_div;
  logic                          is_signed_div;
  logic                          a_signed;
  logic                          b_signed;
  logic signed [2*XLEN+1:0]      prod;
  logic [XLEN-1:0]               a_mag;
  logic [XLEN-1:0]               b_mag;
  logic [XLEN:0]                 rem_shift;
  logic [XLEN+1:0]               trial;
  logic [XLEN-1:0]               quo_fix;
  logic [XLEN-1:0]               rem_fix;

  assign is_div        = md_op inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU};
  assign is_signed_div = md_op inside {MD_DIV, MD_REM};

  // one 33x33 signed multiplier covers all four signedness cases
  assign a_signed = md_op inside {MD_MULH, MD_MULHSU};
  assign b_signed = (md_op == MD_MULH);
  assign prod = $signed({a_signed & a[XLEN-1], a}) * $signed({b_signed & b[XLEN-1], b});

  assign a_mag = (is_signed_div && a[XLEN-1]) ? -a : a;
  assign b_mag = (is_signed_div && b[XLEN-1]) ? -b : b;

  // next dividend bit shifted in, then a trial subtract
  assign rem_shift = {rem, quo[XLEN-1]};
  assign trial     = {1'b0, rem_shift} - {2'b00, dvsr};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      case (state)
        IDLE: begin
          step <= '0;
          if (is_div) begin
            state <= RUN;
          end
        end
        RUN: begin
          step <= step + 1'b1;
          if (step == ($clog2(DIV_STEPS))'(DIV_STEPS - 1)) begin
            state <= DONE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      quo      <= a_mag;
      rem      <= '0;
      dvsr     <= b_mag;
      dvnd_raw <= a;
      neg_quo  <= is_signed_div && (a[XLEN-1] ^ b[XLEN-1]);
      neg_rem  <= is_signed_div && a[XLEN-1];
      div_zero <= (b == '0);
    end else if (state == RUN) begin
      if (trial[XLEN+1]) begin
        rem <= rem_shift[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b0};
      end else begin
        rem <= trial[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b1};
      end
    end
  end

  // most-negative / -1 already comes out right from the magnitudes
  assign quo_fix = div_zero ? '1 : (neg_quo ? -quo : quo);
  assign rem_fix = div_zero ? dvnd_raw : (neg_rem ? -rem : rem);

  always_comb begin
    case (md_op)
      MD_MUL:                        md_result = prod[XLEN-1:0];
      MD_MULH, MD_MULHSU, MD_MULHU:  md_result = prod[2*XLEN-1:XLEN];
      MD_DIV, MD_DIVU:               md_result = quo_fix;
      MD_REM, MD_REMU:               md_result = rem_fix;
      default:                       md_result = '0;
    endcase
  end

  assign md_stall = is_div && (state != DONE);

endmodule

// ==== hw/rv_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32IM core shared definitions
// widths, major opcodes and the operation
// encodings passed between the core units
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  // one quotient bit per divider iteration
  localparam int DIV_STEPS  = 32;

  // major opcodes from the base ISA map
  typedef enum logic [6:0] {
    OP_LUI      = 7'b0110111,
    OP_AUIPC    = 7'b0010111,
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_REG_IMM  = 7'b0010011,
    OP_REG_REG  = 7'b0110011,
    OP_MISC_MEM = 7'b0001111,
    OP_ENVIRON  = 7'b1110011
  } opcode_e;

  // 17 operations, so one bit wider than a nibble
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_LUI,
    // branch compares, result on branch_taken
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU
  } alu_op_e;

  typedef enum logic [3:0] {
    MD_NONE,
    MD_MUL,
    MD_MULH,
    MD_MULHSU,
    MD_MULHU,
    MD_DIV,
    MD_DIVU,
    MD_REM,
    MD_REMU
  } md_op_e;

  typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MULDIV, WB_LINK} wb_sel_e;

  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;

endpackage

// ==== hw/rv_regfile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer register file, 32 x XLEN
// two combinational reads, one sync write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module rv_regfile import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  logic [REG_ADDR_W-1:0] rd,
  input  logic [XLEN-1:0]       rd_data,
  input  logic [REG_ADDR_W-1:0] rs1,
  input  logic [REG_ADDR_W-1:0] rs2,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data
);

  logic [XLEN-1:0] regs [NUM_REGS];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 is cleared on reset and never written, so it reads as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// ==== tests/rv_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32IM reference model for the core testbench
// instruction encoders, xorshift source and an
// instruction-at-a-time ISA model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// architectural state of the model
logic [XLEN-1:0] m_regs [NUM_REGS];
logic [XLEN-1:0] m_pc;
logic [31:0]     rng_state;

function automatic logic [31:0] xorshift32();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OP_REG_REG};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input opcode_e op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input opcode_e op);
  return {imm, rd, op};
endfunction

// branch offset in bytes, bit 0 is dropped by the format
function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
  case (f3)
    3'd0:    return alt ? x - y : x + y;
    3'd1:    return x << y[4:0];
    3'd2:    return {31'b0, $signed(x) < $signed(y)};
    3'd3:    return {31'b0, x < y};
    3'd4:    return x ^ y;
    3'd5:    return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
    3'd6:    return x | y;
    default: return x & y;
  endcase
endfunction

// M extension rules, including divide by zero and signed overflow
function automatic logic [31:0] muldiv_ref(input logic [2:0] f3, input logic [31:0] x,
                                           input logic [31:0] y);
  logic [63:0]        p;
  logic signed [31:0] s;
  logic               ovf;
  ovf = (x == 32'h8000_0000) && (y == 32'hffff_ffff);
  case (f3)
    3'd0: p = {32'b0, x} * {32'b0, y};
    3'd1: p = {{32{x[31]}}, x} * {{32{y[31]}}, y};
    3'd2: p = {{32{x[31]}}, x} * {32'b0, y};
    3'd3: p = {32'b0, x} * {32'b0, y};
    default: p = '0;
  endcase
  if (f3 == 3'd0) begin
    return p[31:0];
  end else if (f3 < 3'd4) begin
    return p[63:32];
  end else if (y == '0) begin
    return (f3[1] == 1'b0) ? 32'hffff_ffff : x;
  end else if (f3 == 3'd4) begin
    if (ovf) begin
      return x;
    end
    s = $signed(x) / $signed(y);
    return s;
  end else if (f3 == 3'd6) begin
    if (ovf) begin
      return 32'd0;
    end
    s = $signed(x) % $signed(y);
    return s;
  end else if (f3 == 3'd5) begin
    return x / y;
  end else begin
    return x % y;
  end
endfunction

function automatic void model_step(input logic [31:0] insn, output logic exp_we,
                                   output logic [4:0] exp_rd, output logic [31:0] exp_data,
                                   output logic exp_halt);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] npc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        wr;
  logic        taken;
  a        = m_regs[insn[19:15]];
  b        = m_regs[insn[24:20]];
  f3       = insn[14:12];
  f7       = insn[31:25];
  imm_i    = {{20{insn[31]}}, insn[31:20]};
  imm_b    = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  imm_j    = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  npc      = m_pc + 32'd4;
  wr       = 1'b0;
  taken    = 1'b0;
  exp_data = '0;
  exp_halt = 1'b0;
  case (insn[6:0])
    OP_LUI: begin
      wr       = 1'b1;
      exp_data = {insn[31:12], 12'b0};
    end
    OP_AUIPC: begin
      wr       = 1'b1;
      exp_data = m_pc + {insn[31:12], 12'b0};
    end
    OP_JAL: begin
      wr       = 1'b1;
      exp_data = m_pc + 32'd4;
      npc      = m_pc + imm_j;
    end
    OP_JALR: begin
      if (f3 == 3'd0) begin
        wr       = 1'b1;
        exp_data = m_pc + 32'd4;
        npc      = (a + imm_i) & ~32'd1;
      end
    end
    OP_BRANCH: begin
      case (f3)
        3'd0:    taken = (a == b);
        3'd1:    taken = (a != b);
        3'd4:    taken = ($signed(a) < $signed(b));
        3'd5:    taken = ($signed(a) >= $signed(b));
        3'd6:    taken = (a < b);
        3'd7:    taken = (a >= b);
        default: taken = 1'b0;
      endcase
      if (taken) begin
        npc = m_pc + imm_b;
      end
    end
    OP_REG_IMM: begin
      // shift immediates only allow funct7 of 0, or 0x20 for SRAI
      if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)) begin
        wr       = 1'b1;
        exp_data = alu_ref(f3, (f3 == 3'd5) && insn[30], a, imm_i);
      end
    end
    OP_REG_REG: begin
      if (f7 == 7'h01) begin
        wr       = 1'b1;
        exp_data = muldiv_ref(f3, a, b);
      end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
        wr       = 1'b1;
        exp_data = alu_ref(f3, insn[30], a, b);
      end
    end
    OP_ENVIRON: begin
      // ecall stops the core on itself
      if (insn[31:7] == '0) begin
        exp_halt = 1'b1;
        npc      = m_pc;
      end
    end
    default: ;
  endcase
  exp_rd = insn[11:7];
  exp_we = wr && (exp_rd != '0);
  if (exp_we) begin
    m_regs[exp_rd] = exp_data;
  end
  m_pc = npc;
endfunction

`endif

// ==== tests/tb_rv_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RV32IM core
// runs a generated program and checks each
// retire against the reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_rv_core import rv_pkg::*; ();

  localparam int IMEM_WORDS   = 1024;
  localparam int RESET_CYCLES = 10;
  localparam int TAIL_CYCLES  = 20;

  logic                  clk;
  logic                  rst;
  logic [XLEN-1:0]       insn;
  logic [XLEN-1:0]       pc;
  logic                  halt;
  logic                  retire_valid;
  logic [XLEN-1:0]       retire_pc;
  logic                  retire_we;
  logic [REG_ADDR_W-1:0] retire_rd;
  logic [XLEN-1:0]       retire_data;
  logic [XLEN-1:0]       imem [IMEM_WORDS];
  int                    prog_len      = 0;
  logic                  program_ready = 1'b0;
  logic                  model_halted  = 1'b0;

  `include "rv_model.svh"

  rv_core u_rv_core (
    .clk, .rst, .insn, .pc, .halt, .retire_valid, .retire_pc, .retire_we, .retire_rd,
    .retire_data
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error at time %0t: %s is %h, expected %h", $time, field, got, exp);
    stop_with_failure();
  endtask

  task automatic put_insn(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [31:0] addi_x5;
    addi_x5 = i_type(12'd1, 5'd5, 3'd0, 5'd5, OP_REG_IMM);
    // unused words hold an illegal opcode tagged with their address
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {i[24:0], 7'h7f};
    end
    for (int i = 1; i < NUM_REGS; i++) begin
      r = xorshift32();
      put_insn(u_type(r[31:12], 5'(i), OP_LUI));
      put_insn(i_type(r[11:0], 5'(i), 3'd0, 5'(i), OP_REG_IMM));
    end
    // random ALU traffic, every 25th one aimed at x0
    for (int n = 0; n < 200; n++) begin
      r  = xorshift32();
      f3 = r[2:0];
      rd = (n % 25 == 0) ? 5'd0 : r[7:3];
      f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[8]) ? 7'h20 : 7'h00;
      if (r[9]) begin
        put_insn(r_type(f7, r[14:10], r[19:15], f3, rd));
      end else if (f3 == 3'd1 || f3 == 3'd5) begin
        put_insn(i_type({f7, r[24:20]}, r[19:15], f3, rd, OP_REG_IMM));
      end else begin
        put_insn(i_type(r[31:20], r[19:15], f3, rd, OP_REG_IMM));
      end
    end
    put_insn(r_type(7'h00, 5'd0, 5'd0, 3'd6, 5'd15));
    // 40 multiplies, then 20 divides
    for (int n = 0; n < 60; n++) begin
      r = xorshift32();
      put_insn(r_type(7'h01, r[14:10], r[19:15], {(n >= 40), r[1:0]}, r[7:3]));
    end
    put_insn(i_type(12'd0, 5'd0, 3'd0, 5'd20, OP_REG_IMM));
    put_insn(u_type(20'h80000, 5'd21, OP_LUI));
    put_insn(i_type(12'hfff, 5'd0, 3'd0, 5'd22, OP_REG_IMM));
    for (int k = 4; k < 8; k++) begin
      put_insn(r_type(7'h01, 5'd20, 5'd5, 3'(k), 5'd23));
      put_insn(r_type(7'h01, 5'd22, 5'd21, 3'(k), 5'd24));
      put_insn(r_type(7'h01, 5'd20, 5'd21, 3'(k), 5'd25));
    end
    // x6 = -5 and x7 = 3 give taken and untaken cases for each kind
    put_insn(i_type(12'hffb, 5'd0, 3'd0, 5'd6, OP_REG_IMM));
    put_insn(i_type(12'd3, 5'd0, 3'd0, 5'd7, OP_REG_IMM));
    for (int k = 0; k < 8; k++) begin
      if (k != 2 && k != 3) begin
        put_insn(b_type(13'd8, 5'd6, 5'd7, 3'(k)));
        put_insn(addi_x5);
        put_insn(b_type(13'd8, 5'd7, 5'd6, 3'(k)));
        put_insn(addi_x5);
        put_insn(b_type(13'd8, 5'd7, 5'd7, 3'(k)));
        put_insn(addi_x5);
      end
    end
    put_insn(j_type(21'd8, 5'd1));
    put_insn(addi_x5);
    // odd jalr offset, target lands past the filler once bit 0 is cleared
    put_insn(u_type(20'd0, 5'd8, OP_AUIPC));
    put_insn(i_type(12'd13, 5'd8, 3'd0, 5'd9, OP_JALR));
    put_insn(addi_x5);
    r = xorshift32();
    put_insn(u_type(r[19:0], 5'd12, OP_LUI));
    put_insn(u_type(r[31:12], 5'd13, OP_AUIPC));
    put_insn(32'h0ff0_000f);
    put_insn(r_type(7'h02, 5'd3, 5'd4, 3'd0, 5'd14));
    put_insn({25'h000_abcd, 7'h7f});
    put_insn(32'h0000_0073);
  endtask

  always @(negedge clk) begin
    insn <= imem[pc[11:2]];
  end

  always @(negedge clk) begin
    logic [XLEN-1:0]       exp_pc;
    logic [XLEN-1:0]       exp_data;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic                  exp_we;
    logic                  exp_halt;
    if (!rst && !model_halted) begin
      if (retire_valid) begin
        exp_pc = m_pc;
        model_step(imem[m_pc[11:2]], exp_we, exp_rd, exp_data, exp_halt);
        assert (retire_pc === exp_pc) else report_mismatch("retire_pc", retire_pc, exp_pc);
        assert (retire_we === exp_we) else report_mismatch("retire_we", retire_we, exp_we);
        if (exp_we) begin
          assert (retire_rd === exp_rd) else report_mismatch("retire_rd", retire_rd, exp_rd);
          assert (retire_data === exp_data)
            else report_mismatch("retire_data", retire_data, exp_data);
        end
        assert (halt === exp_halt) else report_mismatch("halt", halt, exp_halt);
        model_halted = exp_halt;
      end
      // pc holds between retires, so it always matches the model
      assert (pc === m_pc) else report_mismatch("pc", pc, m_pc);
    end
  end

  initial begin
    wait (program_ready);
    repeat (RESET_CYCLES + prog_len * (DIV_STEPS + 4) + TAIL_CYCLES) @(posedge clk);
    $display("timeout: the core never halted on the final ECALL");
    stop_with_failure();
  end

  initial begin
    rst       = 1'b1;
    insn      = '0;
    rng_state = 32'd38522;
    m_pc      = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      m_regs[i] = '0;
    end
    build_program();
    program_ready = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst <= 1'b0;
    wait (model_halted);
    repeat (TAIL_CYCLES) begin
      @(negedge clk);
      assert (!retire_valid && halt && pc === m_pc) else begin
        $display("the core retired, moved pc or dropped halt after the ECALL");
        stop_with_failure();
      end
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+tests
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_muldiv.sv
hw/rv_commit.sv
hw/rv_core.sv
tests/tb_rv_core.sv
